// File: sim.f
verilog/l1d_pkg.sv
verilog/l1d_line_store.sv
verilog/l1d_mshr_queue.sv
verilog/l1d_controller.sv
verilog/l1d_top.sv
verification/l1d_lower_mem.sv
verification/l1d_tb.sv

// File: Bender.yml
package:
  name: l1d_cache

sources:
  - files:
      - verilog/l1d_pkg.sv
      - verilog/l1d_line_store.sv
      - verilog/l1d_mshr_queue.sv
      - verilog/l1d_controller.sv
      - verilog/l1d_top.sv
  - target: test
    files:
      - verification/l1d_lower_mem.sv
      - verification/l1d_tb.sv

// File: verification/l1d_tb.sv
`timescale 1ns/1ps

module l1d_tb;

  localparam int          REQ_COUNT      = 400;
  localparam int          TIMEOUT_CYCLES = REQ_COUNT * 60;
  localparam int          WORD_COUNT     = 1 << (l1d_pkg::ADDR_BITS - 3);
  localparam logic [31:0] SEED           = 32'hb051_56d2;

  logic               clk_in;
  logic               rst_N_in;
  logic               lsu_req_valid;
  logic               lsu_req_ready;
  l1d_pkg::lsu_req_t  lsu_req;
  logic               lsu_resp_valid;
  logic               lsu_resp_ready;
  l1d_pkg::lsu_resp_t lsu_resp;
  logic               mem_req_valid;
  logic               mem_req_ready;
  l1d_pkg::mem_req_t  mem_req;
  logic               mem_fill_valid;
  logic               mem_fill_ready;
  l1d_pkg::mem_fill_t mem_fill;

  // reference model of memory contents and the responses still owed
  logic [63:0]          model [WORD_COUNT];
  l1d_pkg::lsu_resp_t   expected_q [$];
  logic [31:0]          rng;
  int                   cycles;
  int                   issued;
  int                   completed;
  logic                 fill_outstanding;
  l1d_pkg::block_addr_t accepted_block;
  logic                 held;
  l1d_pkg::lsu_resp_t   held_resp;

  l1d_top #(
    .LINE_COUNT (16),
    .MSHR_DEPTH (4)
  ) l1d_top_inst (
    .clk_in         (clk_in),
    .rst_N_in       (rst_N_in),
    .lsu_req_valid  (lsu_req_valid),
    .lsu_req_ready  (lsu_req_ready),
    .lsu_req        (lsu_req),
    .lsu_resp_valid (lsu_resp_valid),
    .lsu_resp_ready (lsu_resp_ready),
    .lsu_resp       (lsu_resp),
    .mem_req_valid  (mem_req_valid),
    .mem_req_ready  (mem_req_ready),
    .mem_req        (mem_req),
    .mem_fill_valid (mem_fill_valid),
    .mem_fill_ready (mem_fill_ready),
    .mem_fill       (mem_fill)
  );

  l1d_lower_mem lower_mem_inst (
    .clk_in         (clk_in),
    .rst_N_in       (rst_N_in),
    .seed           (SEED),
    .mem_req_valid  (mem_req_valid),
    .mem_req_ready  (mem_req_ready),
    .mem_req        (mem_req),
    .mem_fill_valid (mem_fill_valid),
    .mem_fill_ready (mem_fill_ready),
    .mem_fill       (mem_fill)
  );

  always #20 clk_in = ~clk_in;

  function automatic logic [31:0] next_rand();
    rng = rng * 32'd1664525 + 32'd1013904223;
    return rng;
  endfunction

  function automatic logic [63:0] initial_word(input int w);
    logic [31:0] product;
    product = w * 32'h0101_0101;
    return {32'h0, product};
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("*** FAILED ***");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic compare(input string name, input logic [127:0] expected,
                         input logic [127:0] actual);
    if (actual !== expected) begin
      abort_run($sformatf("[ERROR] %s: expected 0x%0h, got 0x%0h", name, expected, actual));
    end
  endtask

  task automatic check_idle_outputs();
    compare("lsu_resp_valid", 1'b0, lsu_resp_valid);
    compare("mem_req_valid", 1'b0, mem_req_valid);
    compare("mem_fill_ready", 1'b0, mem_fill_ready);
    compare("lsu_req_ready", 1'b1, lsu_req_ready);
  endtask

  // a stalled response must keep its payload until the LSU takes it
  task automatic check_held_response();
    if (held) begin
      compare("lsu_resp_valid", 1'b1, lsu_resp_valid);
      compare("lsu_resp", held_resp, lsu_resp);
    end
    held = lsu_resp_valid && !lsu_resp_ready;
    held_resp = lsu_resp;
  endtask

  task automatic check_mem_channel();
    if (mem_fill_valid && mem_fill_ready) begin
      fill_outstanding = 1'b0;
    end
    if (mem_req_valid && mem_req_ready) begin
      if (mem_req.write) begin
        for (int i = 0; i < 4; i++) begin
          compare($sformatf("mem_req.line word %0d", i), model[{mem_req.block, i[1:0]}],
                  mem_req.line[i*64 +: 64]);
        end
      end else begin
        // a second line read before the fill means the miss was not merged
        compare("fill outstanding at line read", 1'b0, fill_outstanding);
        // the line read fetches the block of the request that missed
        compare("mem_req.block", accepted_block, mem_req.block);
        fill_outstanding = 1'b1;
      end
    end
  endtask

  task automatic check_response();
    l1d_pkg::lsu_resp_t expected;
    if (lsu_resp_valid && lsu_resp_ready) begin
      if (expected_q.size() == 0) begin
        abort_run("a response arrived with no request outstanding");
      end else begin
        expected = expected_q.pop_front();
        compare("lsu_resp.tag", expected.tag, lsu_resp.tag);
        compare("lsu_resp.write", expected.write, lsu_resp.write);
        compare("lsu_resp.rdata", expected.rdata, lsu_resp.rdata);
        completed++;
      end
    end
  endtask

  task automatic drive_request();
    l1d_pkg::lsu_resp_t expected;
    l1d_pkg::lsu_req_t  req;
    logic [31:0]        r;
    logic [12:0]        widx;
    logic               can_issue;
    can_issue = !lsu_req_valid;
    if (lsu_req_valid && lsu_req_ready) begin
      widx = lsu_req.addr[15:3];
      accepted_block = lsu_req.addr[15:5];
      expected.tag = lsu_req.tag;
      expected.write = lsu_req.write;
      expected.rdata = lsu_req.write ? 64'h0 : model[widx];
      if (lsu_req.write) begin
        model[widx] = lsu_req.wdata;
      end
      expected_q.push_back(expected);
      issued++;
      lsu_req_valid <= 1'b0;
      can_issue = 1'b1;
    end
    r = next_rand();
    if (can_issue && issued < REQ_COUNT && r[31:30] != 2'b00) begin
      // four tags times four indices times four words, all in conflicting lines
      req.addr = {3'b000, r[29:28], 4'b0000, r[27:26], r[25:24], 3'b000};
      req.write = r[23];
      req.tag = r[21:16];
      req.wdata[63:32] = next_rand();
      req.wdata[31:0] = next_rand();
      lsu_req <= req;
      lsu_req_valid <= 1'b1;
    end
  endtask

  initial begin
    clk_in = 1'b0;
    rst_N_in = 1'b0;
    lsu_req_valid = 1'b0;
    lsu_req = '0;
    lsu_resp_ready = 1'b0;
    rng = SEED;
    cycles = 0;
    issued = 0;
    completed = 0;
    fill_outstanding = 1'b0;
    accepted_block = '0;
    held = 1'b0;
    held_resp = '0;
    for (int w = 0; w < WORD_COUNT; w++) begin
      model[w] = initial_word(w);
    end
    repeat (2) begin
      @(posedge clk_in);
      @(negedge clk_in);
      check_idle_outputs();
    end
    @(posedge clk_in);
    rst_N_in <= 1'b1;
    @(negedge clk_in);
    check_idle_outputs();
    @(negedge clk_in);
    check_idle_outputs();
  end

  always @(posedge clk_in) begin
    logic [31:0] r;
    cycles++;
    if (cycles > TIMEOUT_CYCLES) begin
      abort_run($sformatf("timeout: only %0d of %0d requests completed in %0d cycles",
                          completed, REQ_COUNT, TIMEOUT_CYCLES));
    end else if (rst_N_in) begin
      check_held_response();
      check_mem_channel();
      check_response();
      if (completed == REQ_COUNT) begin
        $display("*** PASSED ***");
        $finish;
      end else begin
        drive_request();
        r = next_rand();
        lsu_resp_ready <= (r[31:16] % 10) < 7;
      end
    end
  end

endmodule

// File: verification/l1d_lower_mem.sv
`timescale 1ns/1ps

module l1d_lower_mem (
  input  logic               clk_in,
  input  logic               rst_N_in,
  input  logic [31:0]        seed,
  input  logic               mem_req_valid,
  output logic               mem_req_ready,
  input  l1d_pkg::mem_req_t  mem_req,
  output logic               mem_fill_valid,
  input  logic               mem_fill_ready,
  output l1d_pkg::mem_fill_t mem_fill
);

  localparam int WORD_COUNT = 1 << (l1d_pkg::ADDR_BITS - 3);

  logic [63:0]          words [WORD_COUNT];
  logic [31:0]          rng;
  logic                 busy;
  logic [3:0]           delay;
  l1d_pkg::block_addr_t fill_block;

  function automatic logic [31:0] lcg_step(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // word w starts as w times 0x01010101, kept to 32 bits
  function automatic logic [63:0] initial_word(input int w);
    logic [31:0] product;
    product = w * 32'h0101_0101;
    return {32'h0, product};
  endfunction

  initial begin
    for (int w = 0; w < WORD_COUNT; w++) begin
      words[w] = initial_word(w);
    end
    mem_req_ready  = 1'b0;
    mem_fill_valid = 1'b0;
    mem_fill       = '0;
  end

  always @(posedge clk_in) begin
    if (!rst_N_in) begin
      rng = seed;
      busy = 1'b0;
      delay = '0;
      mem_req_ready <= 1'b0;
      mem_fill_valid <= 1'b0;
    end else begin
      rng = lcg_step(rng);
      // request channel accepts about three cycles in four
      mem_req_ready <= (rng[31:30] != 2'b00);
      if (mem_fill_valid && mem_fill_ready) begin
        mem_fill_valid <= 1'b0;
      end
      if (mem_req_valid && mem_req_ready) begin
        if (mem_req.write) begin
          for (int i = 0; i < 4; i++) begin
            words[{mem_req.block, i[1:0]}] = mem_req.line[i*64 +: 64];
          end
        end else begin
          busy = 1'b1;
          fill_block = mem_req.block;
          delay = 4'(rng[18:16]) + 4'd1;
        end
      end else if (busy) begin
        if (delay > 4'd1) begin
          delay = delay - 4'd1;
        end else begin
          busy = 1'b0;
          mem_fill_valid <= 1'b1;
          mem_fill.block <= fill_block;
          for (int i = 0; i < 4; i++) begin
            mem_fill.line[i*64 +: 64] <= words[{fill_block, i[1:0]}];
          end
        end
      end
    end
  end

endmodule

// File: verilog/l1d_top.sv
`timescale 1ns/1ps

module l1d_top #(
  parameter int LINE_COUNT = 16,
  parameter int MSHR_DEPTH = 4
) (
  input  logic                clk_in,
  input  logic                rst_N_in,
  input  logic                lsu_req_valid,
  output logic                lsu_req_ready,
  input  l1d_pkg::lsu_req_t   lsu_req,
  output logic                lsu_resp_valid,
  input  logic                lsu_resp_ready,
  output l1d_pkg::lsu_resp_t  lsu_resp,
  output logic                mem_req_valid,
  input  logic                mem_req_ready,
  output l1d_pkg::mem_req_t   mem_req,
  input  logic                mem_fill_valid,
  output logic                mem_fill_ready,
  input  l1d_pkg::mem_fill_t  mem_fill
);

  // controller to and from the MSHR queue
  logic                 q_push;
  l1d_pkg::lsu_req_t    q_push_entry;
  logic                 q_pop;
  logic                 q_open;
  l1d_pkg::lsu_req_t    q_head;
  logic                 q_empty;
  logic                 q_full;
  logic                 q_pending;
  l1d_pkg::block_addr_t q_pending_block;

  // controller to and from the line store
  l1d_pkg::addr_t       ls_lookup_addr;
  logic                 ls_word_we;
  l1d_pkg::word_t       ls_word_data;
  logic                 ls_install_en;
  l1d_pkg::line_t       ls_install_line;
  logic                 ls_hit;
  logic                 ls_victim_dirty;
  l1d_pkg::block_addr_t ls_victim_block;
  l1d_pkg::line_t       ls_victim_line;
  l1d_pkg::word_t       ls_read_word;

  l1d_controller l1d_controller_inst (
    .clk_in         (clk_in),
    .rst_N_in       (rst_N_in),
    .lsu_req_valid  (lsu_req_valid),
    .lsu_req_ready  (lsu_req_ready),
    .lsu_req        (lsu_req),
    .lsu_resp_valid (lsu_resp_valid),
    .lsu_resp_ready (lsu_resp_ready),
    .lsu_resp       (lsu_resp),
    .mem_req_valid  (mem_req_valid),
    .mem_req_ready  (mem_req_ready),
    .mem_req        (mem_req),
    .mem_fill_valid (mem_fill_valid),
    .mem_fill_ready (mem_fill_ready),
    .mem_fill       (mem_fill),
    .push           (q_push),
    .push_entry     (q_push_entry),
    .pop            (q_pop),
    .open           (q_open),
    .head           (q_head),
    .empty          (q_empty),
    .full           (q_full),
    .pending        (q_pending),
    .pending_block  (q_pending_block),
    .lookup_addr    (ls_lookup_addr),
    .word_we        (ls_word_we),
    .word_data      (ls_word_data),
    .install_en     (ls_install_en),
    .install_line   (ls_install_line),
    .hit            (ls_hit),
    .victim_dirty   (ls_victim_dirty),
    .victim_block   (ls_victim_block),
    .victim_line    (ls_victim_line),
    .read_word      (ls_read_word)
  );

  // the episode is opened together with the push of the primary miss
  l1d_mshr_queue #(
    .MSHR_DEPTH (MSHR_DEPTH)
  ) l1d_mshr_queue_inst (
    .clk_in        (clk_in),
    .rst_N_in      (rst_N_in),
    .open          (q_open),
    .block         (q_push_entry.addr[l1d_pkg::ADDR_BITS-1:l1d_pkg::OFFSET_BITS]),
    .push          (q_push),
    .push_entry    (q_push_entry),
    .pop           (q_pop),
    .head          (q_head),
    .empty         (q_empty),
    .full          (q_full),
    .pending       (q_pending),
    .pending_block (q_pending_block)
  );

  l1d_line_store #(
    .LINE_COUNT (LINE_COUNT)
  ) l1d_line_store_inst (
    .clk_in       (clk_in),
    .rst_N_in     (rst_N_in),
    .lookup_addr  (ls_lookup_addr),
    .word_we      (ls_word_we),
    .word_data    (ls_word_data),
    .install_en   (ls_install_en),
    .install_line (ls_install_line),
    .hit          (ls_hit),
    .victim_dirty (ls_victim_dirty),
    .victim_block (ls_victim_block),
    .victim_line  (ls_victim_line),
    .read_word    (ls_read_word)
  );

endmodule

// File: verilog/l1d_controller.sv
`timescale 1ns/1ps

module l1d_controller (
  input  logic                 clk_in,
  input  logic                 rst_N_in,
  input  logic                 lsu_req_valid,
  output logic                 lsu_req_ready,
  input  l1d_pkg::lsu_req_t    lsu_req,
  output logic                 lsu_resp_valid,
  input  logic                 lsu_resp_ready,
  output l1d_pkg::lsu_resp_t   lsu_resp,
  output logic                 mem_req_valid,
  input  logic                 mem_req_ready,
  output l1d_pkg::mem_req_t    mem_req,
  input  logic                 mem_fill_valid,
  output logic                 mem_fill_ready,
  input  l1d_pkg::mem_fill_t   mem_fill,
  output logic                 push,
  output l1d_pkg::lsu_req_t    push_entry,
  output logic                 pop,
  output logic                 open,
  input  l1d_pkg::lsu_req_t    head,
  input  logic                 empty,
  input  logic                 full,
  input  logic                 pending,
  input  l1d_pkg::block_addr_t pending_block,
  output l1d_pkg::addr_t       lookup_addr,
  output logic                 word_we,
  output l1d_pkg::word_t       word_data,
  output logic                 install_en,
  output l1d_pkg::line_t       install_line,
  input  logic                 hit,
  input  logic                 victim_dirty,
  input  l1d_pkg::block_addr_t victim_block,
  input  l1d_pkg::line_t       victim_line,
  input  l1d_pkg::word_t       read_word
);

  l1d_pkg::ctrl_state_t state;
  l1d_pkg::ctrl_state_t next_state;
  l1d_pkg::lsu_req_t    cur_req;
  l1d_pkg::lsu_resp_t   resp_q;
  l1d_pkg::mem_fill_t   fill_q;
  l1d_pkg::lsu_req_t    op;

  logic same_block;
  logic req_fire;
  logic resp_fire;
  logic mem_fire;
  logic fill_fire;
  logic load_resp;

  assign same_block = (lsu_req.addr[l1d_pkg::ADDR_BITS-1:l1d_pkg::OFFSET_BITS] == pending_block);

  // the fill can only come back once the line read has gone out
  assign mem_fill_ready = pending && (state == l1d_pkg::IDLE || state == l1d_pkg::WAIT_FILL);
  assign fill_fire = mem_fill_valid && mem_fill_ready;

  // while a miss is open only the pending block gets in, and a fill takes priority
  assign lsu_req_ready = (state == l1d_pkg::IDLE) && !full && (!pending || same_block) &&
                         !fill_fire;
  assign req_fire = lsu_req_valid && lsu_req_ready;

  assign lsu_resp_valid = (state == l1d_pkg::RESPOND);
  assign lsu_resp = resp_q;
  assign resp_fire = lsu_resp_valid && lsu_resp_ready;

  assign mem_req_valid = (state == l1d_pkg::WRITEBACK) || (state == l1d_pkg::REFILL);
  assign mem_fire = mem_req_valid && mem_req_ready;

  // the victim stays addressed through WRITEBACK, so the payload holds under back-pressure
  always_comb begin
    mem_req.block = pending_block;
    mem_req.write = 1'b0;
    mem_req.line  = '0;
    if (state == l1d_pkg::WRITEBACK) begin
      mem_req.block = victim_block;
      mem_req.write = 1'b1;
      mem_req.line  = victim_line;
    end
  end

  // replay works on the queue head, a fresh lookup on the registered request
  assign op = (state == l1d_pkg::REPLAY) ? head : cur_req;

  always_comb begin
    lookup_addr = op.addr;
    if (state == l1d_pkg::INSTALL) begin
      lookup_addr = {fill_q.block, {l1d_pkg::OFFSET_BITS{1'b0}}};
    end
  end

  assign word_data = op.wdata;
  assign word_we = op.write && ((state == l1d_pkg::LOOKUP && hit) ||
                                (state == l1d_pkg::REPLAY && !empty));
  assign install_en = (state == l1d_pkg::INSTALL);
  assign install_line = fill_q.line;

  // every miss is queued; only the first one of an episode opens it
  assign push = (state == l1d_pkg::LOOKUP) && !hit;
  assign push_entry = cur_req;
  assign open = push && !pending;
  assign pop = (state == l1d_pkg::REPLAY) && !empty;

  assign load_resp = ((state == l1d_pkg::LOOKUP) && hit) || pop;

  always_comb begin
    next_state = state;
    case (state)
      l1d_pkg::IDLE: begin
        if (fill_fire) begin
          next_state = l1d_pkg::INSTALL;
        end else if (req_fire) begin
          next_state = l1d_pkg::LOOKUP;
        end
      end
      l1d_pkg::LOOKUP: begin
        if (hit) begin
          next_state = l1d_pkg::RESPOND;
        end else if (pending) begin
          // secondary miss, merged into the open episode
          next_state = l1d_pkg::IDLE;
        end else if (victim_dirty) begin
          next_state = l1d_pkg::WRITEBACK;
        end else begin
          next_state = l1d_pkg::REFILL;
        end
      end
      l1d_pkg::RESPOND: begin
        // pending is still set while replay has entries left
        if (resp_fire) begin
          next_state = pending ? l1d_pkg::REPLAY : l1d_pkg::IDLE;
        end
      end
      l1d_pkg::WRITEBACK: begin
        if (mem_fire) begin
          next_state = l1d_pkg::REFILL;
        end
      end
      l1d_pkg::REFILL: begin
        if (mem_fire) begin
          next_state = l1d_pkg::WAIT_FILL;
        end
      end
      l1d_pkg::WAIT_FILL: begin
        next_state = fill_fire ? l1d_pkg::INSTALL : l1d_pkg::IDLE;
      end
      l1d_pkg::INSTALL: begin
        next_state = l1d_pkg::REPLAY;
      end
      l1d_pkg::REPLAY: begin
        next_state = empty ? l1d_pkg::IDLE : l1d_pkg::RESPOND;
      end
      default: begin
        next_state = l1d_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_in) begin
    if (!rst_N_in) begin
      state <= l1d_pkg::IDLE;
    end else begin
      state <= next_state;
    end
  end

  always_ff @(posedge clk_in) begin
    if (req_fire) begin
      cur_req <= lsu_req;
    end
    if (fill_fire) begin
      fill_q <= mem_fill;
    end
    if (load_resp) begin
      resp_q.tag   <= op.tag;
      resp_q.write <= op.write;
      resp_q.rdata <= op.write ? '0 : read_word;
    end
  end

endmodule

// File: verilog/l1d_mshr_queue.sv
`timescale 1ns/1ps

module l1d_mshr_queue #(
  parameter int MSHR_DEPTH = 4
) (
  input  logic                 clk_in,
  input  logic                 rst_N_in,
  input  logic                 open,
  input  l1d_pkg::block_addr_t block,
  input  logic                 push,
  input  l1d_pkg::lsu_req_t    push_entry,
  input  logic                 pop,
  output l1d_pkg::lsu_req_t    head,
  output logic                 empty,
  output logic                 full,
  output logic                 pending,
  output l1d_pkg::block_addr_t pending_block
);

  localparam int PTR_BITS   = (MSHR_DEPTH > 1) ? $clog2(MSHR_DEPTH) : 1;
  localparam int COUNT_BITS = $clog2(MSHR_DEPTH + 1);

  l1d_pkg::lsu_req_t     entries [MSHR_DEPTH];
  logic [PTR_BITS-1:0]   wr_ptr;
  logic [PTR_BITS-1:0]   rd_ptr;
  logic [COUNT_BITS-1:0] count;
  logic                  do_push;
  logic                  do_pop;

  // pointers wrap at the depth, which need not be a power of two
  function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] ptr);
    if (ptr == PTR_BITS'(MSHR_DEPTH - 1)) begin
      return '0;
    end else begin
      return ptr + 1'b1;
    end
  endfunction

  assign empty = (count == '0);
  assign full = (count == COUNT_BITS'(MSHR_DEPTH));
  assign head = entries[rd_ptr];
  assign do_push = push && !full;
  assign do_pop = pop && !empty;

  always_ff @(posedge clk_in) begin
    if (!rst_N_in) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      pending <= 1'b0;
    end else begin
      if (do_push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
      // the episode ends when replay drains the last entry
      if (open) begin
        pending <= 1'b1;
      end else if (do_pop && !do_push && count == COUNT_BITS'(1)) begin
        pending <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (do_push) begin
      entries[wr_ptr] <= push_entry;
    end
    if (open) begin
      pending_block <= block;
    end
  end

endmodule

// File: verilog/l1d_line_store.sv
`timescale 1ns/1ps

module l1d_line_store #(
  parameter int LINE_COUNT = 16
) (
  input  logic                 clk_in,
  input  logic                 rst_N_in,
  input  l1d_pkg::addr_t       lookup_addr,
  input  logic                 word_we,
  input  l1d_pkg::word_t       word_data,
  input  logic                 install_en,
  input  l1d_pkg::line_t       install_line,
  output logic                 hit,
  output logic                 victim_dirty,
  output l1d_pkg::block_addr_t victim_block,
  output l1d_pkg::line_t       victim_line,
  output l1d_pkg::word_t       read_word
);

  localparam int INDEX_BITS = $clog2(LINE_COUNT);
  localparam int CTAG_BITS  = l1d_pkg::ADDR_BITS - l1d_pkg::OFFSET_BITS - INDEX_BITS;
  localparam int WORD_LSB   = l1d_pkg::OFFSET_BITS - l1d_pkg::WORD_SEL_BITS;

  logic [LINE_COUNT-1:0] valid_bits;
  logic [LINE_COUNT-1:0] dirty_bits;
  logic [CTAG_BITS-1:0]  tag_array  [LINE_COUNT];
  l1d_pkg::line_t        data_array [LINE_COUNT];

  logic [INDEX_BITS-1:0]             index;
  logic [CTAG_BITS-1:0]              ctag;
  logic [l1d_pkg::WORD_SEL_BITS-1:0] word_sel;

  // address splits into cache tag, line index, word select and byte offset
  assign ctag = lookup_addr[l1d_pkg::ADDR_BITS-1 -: CTAG_BITS];
  assign index = lookup_addr[l1d_pkg::OFFSET_BITS +: INDEX_BITS];
  assign word_sel = lookup_addr[l1d_pkg::OFFSET_BITS-1:WORD_LSB];

  assign hit = valid_bits[index] && (tag_array[index] == ctag);
  assign victim_dirty = valid_bits[index] && dirty_bits[index];
  assign victim_block = {tag_array[index], index};
  assign victim_line = data_array[index];
  assign read_word = data_array[index][word_sel*l1d_pkg::DATA_BITS +: l1d_pkg::DATA_BITS];

  // a fresh line arrives clean, a store makes it dirty
  always_ff @(posedge clk_in) begin
    if (!rst_N_in) begin
      valid_bits <= '0;
      dirty_bits <= '0;
    end else if (install_en) begin
      valid_bits[index] <= 1'b1;
      dirty_bits[index] <= 1'b0;
    end else if (word_we) begin
      dirty_bits[index] <= 1'b1;
    end
  end

  always_ff @(posedge clk_in) begin
    if (install_en) begin
      tag_array[index]  <= ctag;
      data_array[index] <= install_line;
    end else if (word_we) begin
      data_array[index][word_sel*l1d_pkg::DATA_BITS +: l1d_pkg::DATA_BITS] <= word_data;
    end
  end

endmodule

// File: verilog/l1d_pkg.sv
package l1d_pkg;

  // geometry of the address and of one line
  parameter int ADDR_BITS      = 16;
  parameter int DATA_BITS      = 64;
  parameter int WORDS_PER_LINE = 4;
  parameter int OFFSET_BITS    = 5;
  parameter int WORD_SEL_BITS  = 2;
  parameter int REQ_TAG_BITS   = 6;

  typedef logic [ADDR_BITS-1:0] addr_t;
  typedef logic [ADDR_BITS-OFFSET_BITS-1:0] block_addr_t;
  typedef logic [DATA_BITS-1:0] word_t;
  // word 0 sits in the low bits of the line
  typedef logic [WORDS_PER_LINE*DATA_BITS-1:0] line_t;

  // request from the load/store unit, also the entry kept in the MSHR queue
  typedef struct packed {
    addr_t                   addr;
    logic                    write;
    word_t                   wdata;
    logic [REQ_TAG_BITS-1:0] tag;
  } lsu_req_t;

  // read data is zero when the response completes a write
  typedef struct packed {
    logic [REQ_TAG_BITS-1:0] tag;
    logic                    write;
    word_t                   rdata;
  } lsu_resp_t;

  // write is set for a writeback, line is ignored on a line read
  typedef struct packed {
    block_addr_t block;
    logic        write;
    line_t       line;
  } mem_req_t;

  typedef struct packed {
    block_addr_t block;
    line_t       line;
  } mem_fill_t;

  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    RESPOND,
    WRITEBACK,
    REFILL,
    WAIT_FILL,
    INSTALL,
    REPLAY
  } ctrl_state_t;

endpackage
